// File: verilog/dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

  // Bus and counter widths.
  localparam int ADDR_W = 32;
  localparam int CSR_W  = 32;
  localparam int TSZ_W  = 12;
  localparam int BST_W  = 9;                // Holds up to 256 beats.

  // Control word field positions.
  localparam int CSR_DMOD_LSB = 3;          // Bits 4:3.
  localparam int CSR_SMOD_LSB = 5;          // Bits 6:5.
  localparam int CSR_DWID_LSB = 8;          // Bits 10:8.
  localparam int CSR_SWID_LSB = 11;         // Bits 13:11.
  localparam int CSR_SSZ_LSB  = 16;         // Bits 18:16.

  // Transfer width codes in HSIZE encoding.
  localparam logic [2:0] HSIZE_BYTE = 3'd0;
  localparam logic [2:0] HSIZE_HALF = 3'd1;
  localparam logic [2:0] HSIZE_WORD = 3'd2;

  // Address modes; upper bit set means fixed.
  localparam logic [1:0] AMOD_INC = 2'b00;
  localparam logic [1:0] AMOD_DEC = 2'b01;

endpackage

`default_nettype wire

// File: verilog/dma_state_pkg.sv
`default_nettype none

package dma_state_pkg;

  localparam int ST_W = 4;

  // Bit positions inside the one-hot state word.
  localparam int ST_IDLE_B   = 0;
  localparam int ST_RD_B     = 1;
  localparam int ST_WR_B     = 2;
  localparam int ST_UPDATE_B = 3;

  localparam logic [ST_W-1:0] ST_IDLE   = 4'b0001;
  localparam logic [ST_W-1:0] ST_RD     = 4'b0010;
  localparam logic [ST_W-1:0] ST_WR     = 4'b0100;
  localparam logic [ST_W-1:0] ST_UPDATE = 4'b1000;

endpackage

`default_nettype wire

// File: verilog/dma_csr_decode.sv
`default_nettype none

module dma_csr_decode (
  input  wire [dma_cfg_pkg::CSR_W-1:0]         arb_chcsr,
  output logic [dma_cfg_pkg::BST_W-1:0]        bst_len,
  output logic signed [dma_cfg_pkg::ADDR_W-1:0] src_step,
  output logic signed [dma_cfg_pkg::ADDR_W-1:0] dst_step
);

  // Byte step for one beat signed by the address mode.
  function automatic logic signed [dma_cfg_pkg::ADDR_W-1:0] beat_step(
    input logic [1:0] amod,
    input logic [2:0] wid
  );
    logic signed [dma_cfg_pkg::ADDR_W-1:0] w;
    case (wid)
      dma_cfg_pkg::HSIZE_BYTE: w = 1;
      dma_cfg_pkg::HSIZE_HALF: w = 2;
      dma_cfg_pkg::HSIZE_WORD: w = 4;
      default:                 w = 1;       // Reserved widths step as bytes.
    endcase
    if (amod[1])
      beat_step = '0;                       // Fixed address.
    else if (amod == dma_cfg_pkg::AMOD_DEC)
      beat_step = -w;
    else
      beat_step = w;
  endfunction

  always_comb begin
    case (arb_chcsr[dma_cfg_pkg::CSR_SSZ_LSB +: 3])
      3'd0:    bst_len = 9'd1;
      3'd1:    bst_len = 9'd4;
      3'd2:    bst_len = 9'd8;
      3'd3:    bst_len = 9'd16;
      3'd4:    bst_len = 9'd32;
      3'd5:    bst_len = 9'd64;
      3'd6:    bst_len = 9'd128;
      default: bst_len = 9'd256;
    endcase
  end

  assign src_step = beat_step(arb_chcsr[dma_cfg_pkg::CSR_SMOD_LSB +: 2],
                              arb_chcsr[dma_cfg_pkg::CSR_SWID_LSB +: 3]);
  assign dst_step = beat_step(arb_chcsr[dma_cfg_pkg::CSR_DMOD_LSB +: 2],
                              arb_chcsr[dma_cfg_pkg::CSR_DWID_LSB +: 3]);

endmodule

`default_nettype wire

// File: verilog/dma_xfer_fsm.sv
`default_nettype none

module dma_xfer_fsm (
  input  wire                               HCLK,
  input  wire                               HRSTn,
  input  wire                               arb_req,
  input  wire [dma_cfg_pkg::TSZ_W-1:0]      arb_chtsz,
  input  wire                               arb_chabt,
  input  wire [dma_cfg_pkg::BST_W-1:0]      bst_len,
  input  wire                               m_rdy,
  input  wire                               m_err,
  output logic [dma_state_pkg::ST_W-1:0]    de_st,
  output logic                              start,
  output logic                              rd_beat,
  output logic                              wr_beat,
  output logic                              tsz_eq0,
  output logic [dma_cfg_pkg::TSZ_W-1:0]     de_tsz,
  output logic                              de_tsz_we,
  output logic                              m_arb_dst,
  output logic                              de_busy
);

  logic [dma_state_pkg::ST_W-1:0] st;
  logic [dma_state_pkg::ST_W-1:0] nxt;
  logic [dma_cfg_pkg::TSZ_W-1:0]  tsz_cnt;
  logic [dma_cfg_pkg::BST_W-1:0]  bst_cnt;
  logic [dma_cfg_pkg::BST_W-1:0]  wr_cnt;  // Beats read but not yet written.
  logic                           st_idle;
  logic                           st_rd;
  logic                           st_wr;
  logic                           rd_last;
  logic                           wr_last;
  logic                           bail;

  assign st_idle = st[dma_state_pkg::ST_IDLE_B];
  assign st_rd   = st[dma_state_pkg::ST_RD_B];
  assign st_wr   = st[dma_state_pkg::ST_WR_B];

  assign start   = st_idle & arb_req;      // Grant only counts when idle.
  assign rd_beat = st_rd & m_rdy;
  assign wr_beat = st_wr & m_rdy;

  assign rd_last = rd_beat & ((bst_cnt == 1) | (tsz_cnt == 1));
  assign wr_last = wr_beat & (wr_cnt == 1);
  assign bail    = (m_rdy & m_err) | arb_chabt;

  always_comb begin
    nxt = st;
    case (st)
      dma_state_pkg::ST_IDLE: begin
        if (start)
          nxt = (arb_chtsz == 0) ? dma_state_pkg::ST_UPDATE : dma_state_pkg::ST_RD;
      end
      dma_state_pkg::ST_RD: begin
        if (bail)
          nxt = dma_state_pkg::ST_UPDATE;
        else if (rd_last)
          nxt = dma_state_pkg::ST_WR;
      end
      dma_state_pkg::ST_WR: begin
        if (bail | wr_last)
          nxt = dma_state_pkg::ST_UPDATE;
      end
      default: nxt = dma_state_pkg::ST_IDLE;  // UPDATE lasts one cycle.
    endcase
  end

  always_ff @(posedge HCLK or negedge HRSTn) begin
    if (!HRSTn)
      st <= dma_state_pkg::ST_IDLE;
    else
      st <= nxt;
  end

  always_ff @(posedge HCLK or negedge HRSTn) begin
    if (!HRSTn) begin
      tsz_cnt <= '0;
      bst_cnt <= '0;
      wr_cnt  <= '0;
    end else if (start) begin
      tsz_cnt <= arb_chtsz;
      bst_cnt <= bst_len;
      wr_cnt  <= '0;
    end else if (rd_beat) begin
      tsz_cnt <= de_tsz;
      bst_cnt <= bst_cnt - 1;
      wr_cnt  <= wr_cnt + 1;
    end else if (wr_beat) begin
      wr_cnt  <= wr_cnt - 1;
    end
  end

  assign de_tsz    = tsz_cnt - 1;           // Remaining size after this beat.
  assign de_tsz_we = rd_beat;
  assign tsz_eq0   = (tsz_cnt == 0);

  assign de_st     = st;
  assign m_arb_dst = st_wr;
  assign de_busy   = ~st_idle;

endmodule

`default_nettype wire

// File: verilog/dma_addr_update.sv
`default_nettype none

module dma_addr_update (
  input  wire                                HCLK,
  input  wire                                HRSTn,
  input  wire                                start,
  input  wire                                rd_beat,
  input  wire                                wr_beat,
  input  wire [dma_cfg_pkg::ADDR_W-1:0]      arb_chsad,
  input  wire [dma_cfg_pkg::ADDR_W-1:0]      arb_chdad,
  input  wire signed [dma_cfg_pkg::ADDR_W-1:0] src_step,
  input  wire signed [dma_cfg_pkg::ADDR_W-1:0] dst_step,
  output logic [dma_cfg_pkg::ADDR_W-1:0]     de_sad,
  output logic                               de_sad_we,
  output logic [dma_cfg_pkg::ADDR_W-1:0]     de_dad,
  output logic                               de_dad_we
);

  logic [dma_cfg_pkg::ADDR_W-1:0] sad_q;
  logic [dma_cfg_pkg::ADDR_W-1:0] dad_q;

  // Two's complement add covers the decrement case as well.
  assign de_sad = sad_q + src_step;
  assign de_dad = dad_q + dst_step;

  assign de_sad_we = rd_beat;
  assign de_dad_we = wr_beat;

  always_ff @(posedge HCLK or negedge HRSTn) begin
    if (!HRSTn)
      sad_q <= '0;
    else if (start)
      sad_q <= arb_chsad;                  // Start of grant.
    else if (rd_beat)
      sad_q <= de_sad;
  end

  always_ff @(posedge HCLK or negedge HRSTn) begin
    if (!HRSTn)
      dad_q <= '0;
    else if (start)
      dad_q <= arb_chdad;
    else if (wr_beat)
      dad_q <= de_dad;
  end

endmodule

`default_nettype wire

// File: verilog/dma_status.sv
`default_nettype none

module dma_status (
  input  wire                             HCLK,
  input  wire                             HRSTn,
  input  wire [dma_state_pkg::ST_W-1:0]   de_st,
  input  wire                             tsz_eq0,
  input  wire                             arb_chabt,
  input  wire                             m_err,
  input  wire                             rd_beat,
  input  wire                             wr_beat,
  output logic                            de_err_st,
  output logic                            de_ack,
  output logic                            de_tc_st,
  output logic                            de_en_clr
);

  logic st_update;
  logic err_notify;

  assign st_update = de_st[dma_state_pkg::ST_UPDATE_B];

  // m_err is only meaningful with a completed beat.
  assign de_err_st = m_err & (rd_beat | wr_beat);

  always_ff @(posedge HCLK or negedge HRSTn) begin
    if (!HRSTn)
      err_notify <= 1'b0;
    else if (de_err_st)
      err_notify <= 1'b1;
    else if (st_update)
      err_notify <= 1'b0;                  // Reported with this grant.
  end

  assign de_ack    = st_update;
  assign de_tc_st  = st_update & tsz_eq0 & ~err_notify;
  assign de_en_clr = st_update & (arb_chabt | err_notify | tsz_eq0);

endmodule

`default_nettype wire

// File: verilog/dma_engine.sv
`default_nettype none

module dma_engine (
  input  wire                               HCLK,
  input  wire                               HRSTn,
  input  wire                               arb_req,
  input  wire [dma_cfg_pkg::CSR_W-1:0]      arb_chcsr,
  input  wire [dma_cfg_pkg::TSZ_W-1:0]      arb_chtsz,
  input  wire [dma_cfg_pkg::ADDR_W-1:0]     arb_chsad,
  input  wire [dma_cfg_pkg::ADDR_W-1:0]     arb_chdad,
  input  wire                               arb_chabt,
  input  wire                               m_rdy,
  input  wire                               m_err,
  output logic                              m_arb_dst,
  output logic [dma_cfg_pkg::TSZ_W-1:0]     de_tsz,
  output logic                              de_tsz_we,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    de_sad,
  output logic                              de_sad_we,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    de_dad,
  output logic                              de_dad_we,
  output logic                              de_ack,
  output logic                              de_tc_st,
  output logic                              de_en_clr,
  output logic                              de_err_st,
  output logic                              de_busy,
  output logic [dma_state_pkg::ST_W-1:0]    de_st
);

  logic [dma_cfg_pkg::BST_W-1:0]         bst_len;
  logic signed [dma_cfg_pkg::ADDR_W-1:0] src_step;
  logic signed [dma_cfg_pkg::ADDR_W-1:0] dst_step;
  logic                                  start;
  logic                                  rd_beat;
  logic                                  wr_beat;
  logic                                  tsz_eq0;

  dma_csr_decode u_decode (
    .arb_chcsr (arb_chcsr),
    .bst_len   (bst_len),
    .src_step  (src_step),
    .dst_step  (dst_step)
  );

  dma_xfer_fsm u_fsm (
    .HCLK      (HCLK),
    .HRSTn     (HRSTn),
    .arb_req   (arb_req),
    .arb_chtsz (arb_chtsz),
    .arb_chabt (arb_chabt),
    .bst_len   (bst_len),
    .m_rdy     (m_rdy),
    .m_err     (m_err),
    .de_st     (de_st),
    .start     (start),
    .rd_beat   (rd_beat),
    .wr_beat   (wr_beat),
    .tsz_eq0   (tsz_eq0),
    .de_tsz    (de_tsz),
    .de_tsz_we (de_tsz_we),
    .m_arb_dst (m_arb_dst),
    .de_busy   (de_busy)
  );

  dma_addr_update u_addr (
    .HCLK      (HCLK),
    .HRSTn     (HRSTn),
    .start     (start),
    .rd_beat   (rd_beat),
    .wr_beat   (wr_beat),
    .arb_chsad (arb_chsad),
    .arb_chdad (arb_chdad),
    .src_step  (src_step),
    .dst_step  (dst_step),
    .de_sad    (de_sad),
    .de_sad_we (de_sad_we),
    .de_dad    (de_dad),
    .de_dad_we (de_dad_we)
  );

  dma_status u_status (
    .HCLK      (HCLK),
    .HRSTn     (HRSTn),
    .de_st     (de_st),
    .tsz_eq0   (tsz_eq0),
    .arb_chabt (arb_chabt),
    .m_err     (m_err),
    .rd_beat   (rd_beat),
    .wr_beat   (wr_beat),
    .de_err_st (de_err_st),
    .de_ack    (de_ack),
    .de_tc_st  (de_tc_st),
    .de_en_clr (de_en_clr)
  );

endmodule

`default_nettype wire

// File: tb/dma_engine_assertions.sv
`default_nettype none

module dma_engine_assertions (
  input wire                           HCLK,
  input wire                           HRSTn,
  input wire [dma_state_pkg::ST_W-1:0] de_st,
  input wire                           de_ack,
  input wire                           de_tc_st,
  input wire                           de_en_clr,
  input wire                           m_rdy,
  input wire                           m_err
);

  int fail_count = 0;

  st_onehot: assert property (@(posedge HCLK) disable iff (!HRSTn) $onehot(de_st))
    else begin
      $error("de_st is not one-hot");
      fail_count++;
    end

  ack_pulse: assert property (@(posedge HCLK) disable iff (!HRSTn)
    de_ack |=> (!de_ack && de_st == dma_state_pkg::ST_IDLE))
    else begin
      $error("de_ack not a single cycle followed by IDLE");
      fail_count++;
    end

  err_with_rdy: assert property (@(posedge HCLK) disable iff (!HRSTn) m_err |-> m_rdy)
    else begin
      $error("m_err without m_rdy");
      fail_count++;
    end

  status_with_ack: assert property (@(posedge HCLK) disable iff (!HRSTn)
    (de_tc_st || de_en_clr) |-> de_ack)
    else begin
      $error("de_tc_st or de_en_clr outside de_ack");
      fail_count++;
    end

endmodule

bind dma_engine dma_engine_assertions u_assert (
  .HCLK      (HCLK),
  .HRSTn     (HRSTn),
  .de_st     (de_st),
  .de_ack    (de_ack),
  .de_tc_st  (de_tc_st),
  .de_en_clr (de_en_clr),
  .m_rdy     (m_rdy),
  .m_err     (m_err)
);

`default_nettype wire

// File: tb/dma_engine_tb.sv
`default_nettype none

module dma_engine_tb;

  logic                           HCLK;
  logic                           HRSTn;
  logic                           arb_req;
  logic [dma_cfg_pkg::CSR_W-1:0]  arb_chcsr;
  logic [dma_cfg_pkg::TSZ_W-1:0]  arb_chtsz;
  logic [dma_cfg_pkg::ADDR_W-1:0] arb_chsad;
  logic [dma_cfg_pkg::ADDR_W-1:0] arb_chdad;
  logic                           arb_chabt;
  logic                           m_rdy;
  logic                           m_err;
  logic                           m_arb_dst;
  logic [dma_cfg_pkg::TSZ_W-1:0]  de_tsz;
  logic [dma_cfg_pkg::ADDR_W-1:0] de_sad;
  logic [dma_cfg_pkg::ADDR_W-1:0] de_dad;
  logic                           de_tsz_we, de_sad_we, de_dad_we;
  logic                           de_ack, de_tc_st, de_en_clr, de_err_st, de_busy;
  logic [dma_state_pkg::ST_W-1:0] de_st;

  logic [dma_cfg_pkg::ADDR_W-1:0] exp_sad, exp_dad, s_step, d_step;  // Model of the grant.
  logic [dma_cfg_pkg::TSZ_W-1:0]  exp_tsz;
  logic [dma_cfg_pkg::TSZ_W-1:0]  last_tsz;                          // Size written back.
  int                             n_rd, n_wr, n_err;
  logic                           got_tc, got_en_clr;

  dma_engine dut (.*);

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  always @(dut.u_assert.fail_count) begin
    if (dut.u_assert.fail_count != 0)
      fail_run("A concurrent assertion on the engine failed");
  end

  // Signed byte step per beat for a mode and width.
  function automatic logic [31:0] step_of(input logic [1:0] mode, input logic [2:0] wid);
    logic [31:0] bytes;
    bytes = 32'd1 << wid;
    if (mode[1])
      return 32'd0;
    if (mode[0])
      return -bytes;
    return bytes;
  endfunction

  function automatic int burst_of(input logic [2:0] code);
    return (code == 3'd0) ? 1 : (2 << code);
  endfunction

  function automatic logic [31:0] make_csr(input logic [2:0] ssz, input logic [1:0] smod,
                                           input logic [2:0] swid, input logic [1:0] dmod,
                                           input logic [2:0] dwid);
    logic [31:0] c;
    c = '0;
    c[dma_cfg_pkg::CSR_SSZ_LSB +: 3]  = ssz;
    c[dma_cfg_pkg::CSR_SMOD_LSB +: 2] = smod;
    c[dma_cfg_pkg::CSR_SWID_LSB +: 3] = swid;
    c[dma_cfg_pkg::CSR_DMOD_LSB +: 2] = dmod;
    c[dma_cfg_pkg::CSR_DWID_LSB +: 3] = dwid;
    return c;
  endfunction

  // One-cycle request; the channel words stay held afterwards.
  task automatic grant(input logic [31:0] csr, input logic [11:0] tsz,
                       input logic [31:0] sad, input logic [31:0] dad);
    @(negedge HCLK);
    expect_eq("de_busy", 32'(de_busy), 32'd0);
    arb_chcsr = csr;
    arb_chtsz = tsz;
    arb_chsad = sad;
    arb_chdad = dad;
    arb_req   = 1'b1;
    exp_sad   = sad;
    exp_dad   = dad;
    exp_tsz   = tsz;
    s_step    = step_of(csr[dma_cfg_pkg::CSR_SMOD_LSB +: 2], csr[dma_cfg_pkg::CSR_SWID_LSB +: 3]);
    d_step    = step_of(csr[dma_cfg_pkg::CSR_DMOD_LSB +: 2], csr[dma_cfg_pkg::CSR_DWID_LSB +: 3]);
    @(negedge HCLK);
    arb_req = 1'b0;
  endtask

  // Serves beats with random gaps until de_ack, with an optional error or abort.
  task automatic serve_grant(input int err_at, input int abt_at);
    int cycles;
    n_rd   = 0;
    n_wr   = 0;
    n_err  = 0;
    cycles = 0;
    while (de_ack !== 1'b1) begin
      cycles++;
      if (cycles > 1000)
        fail_run("Timed out waiting for de_ack from the engine");
      expect_eq("de_busy", 32'(de_busy), 32'd1);
      m_rdy = (($urandom % 4) != 0);
      m_err = 1'b0;
      if (!m_arb_dst && n_rd == abt_at) begin
        arb_chabt = 1'b1;
        m_rdy     = 1'b0;
      end
      if (m_rdy && !m_arb_dst && n_rd == err_at)
        m_err = 1'b1;
      #1;
      expect_eq("de_tsz_we", 32'(de_tsz_we), 32'(m_rdy & ~m_arb_dst));
      expect_eq("de_sad_we", 32'(de_sad_we), 32'(m_rdy & ~m_arb_dst));
      expect_eq("de_dad_we", 32'(de_dad_we), 32'(m_rdy & m_arb_dst));
      expect_eq("de_err_st", 32'(de_err_st), 32'(m_err));
      if (de_err_st)
        n_err++;
      if (m_rdy && !m_arb_dst) begin
        exp_sad = exp_sad + s_step;
        exp_tsz = exp_tsz - 1'b1;
        expect_eq("de_sad", de_sad, exp_sad);
        expect_eq("de_tsz", 32'(de_tsz), 32'(exp_tsz));
        last_tsz = de_tsz;
        n_rd++;
      end else if (m_rdy) begin
        exp_dad = exp_dad + d_step;
        expect_eq("de_dad", de_dad, exp_dad);
        n_wr++;
      end
      @(negedge HCLK);
    end
    got_tc     = de_tc_st;
    got_en_clr = de_en_clr;
    m_err      = 1'b0;
    m_rdy      = 1'b1;                     // A stray beat in UPDATE must be ignored.
    #1;
    expect_eq("de_tsz_we", 32'(de_tsz_we), 32'd0);
    expect_eq("de_sad_we", 32'(de_sad_we), 32'd0);
    expect_eq("de_dad_we", 32'(de_dad_we), 32'd0);
    m_rdy     = 1'b0;
    arb_chabt = 1'b0;
    @(negedge HCLK);
    expect_eq("de_st", 32'(de_st), 32'(dma_state_pkg::ST_IDLE));
  endtask

  task automatic expect_end(input int rd, input int wr, input logic tc, input logic en_clr);
    expect_eq("read beats", n_rd, rd);
    expect_eq("write beats", n_wr, wr);
    expect_eq("de_tc_st", 32'(got_tc), 32'(tc));
    expect_eq("de_en_clr", 32'(got_en_clr), 32'(en_clr));
  endtask

  task automatic short_xfer();
    grant(make_csr(3'd2, 2'b00, 3'd2, 2'b00, 3'd2), 12'd5, 32'h1000, 32'h2000);
    serve_grant(-1, -1);
    expect_end(5, 5, 1'b1, 1'b1);
    expect_eq("remaining size", 32'(last_tsz), 32'd0);
  endtask

  task automatic two_grant_xfer();
    grant(make_csr(3'd1, 2'b00, 3'd1, 2'b00, 3'd0), 12'd7, 32'h3000, 32'h4000);
    serve_grant(-1, -1);
    expect_end(4, 4, 1'b0, 1'b0);
    expect_eq("remaining size", 32'(last_tsz), 32'd3);
    grant(arb_chcsr, last_tsz, exp_sad, exp_dad);
    serve_grant(-1, -1);
    expect_end(3, 3, 1'b1, 1'b1);
  endtask

  task automatic addr_modes();
    int         tsz;
    int         bst;
    logic [2:0] ssz;
    for (int i = 0; i < 8; i++) begin
      ssz = 3'($urandom % 4);
      tsz = 1 + int'($urandom % 12);
      bst = burst_of(ssz);
      grant(make_csr(ssz, 2'(i % 4), 3'($urandom % 3), 2'((i + 1) % 4), 3'($urandom % 3)),
            12'(tsz), $urandom, $urandom);
      serve_grant(-1, -1);
      expect_eq("read beats", n_rd, (tsz < bst) ? tsz : bst);
      expect_eq("write beats", n_wr, n_rd);
    end
  endtask

  task automatic read_error();
    grant(make_csr(3'd2, 2'b00, 3'd2, 2'b01, 3'd2), 12'd6, 32'h5000, 32'h6000);
    serve_grant(2, -1);
    expect_end(3, 0, 1'b0, 1'b1);          // The erroring beat still counts.
    expect_eq("error beats", n_err, 1);
    grant(make_csr(3'd2, 2'b00, 3'd2, 2'b01, 3'd2), 12'd3, 32'h5100, 32'h6100);
    serve_grant(2, -1);
    expect_end(3, 0, 1'b0, 1'b1);          // Error on the last read beat.
  endtask

  task automatic mid_abort();
    grant(make_csr(3'd3, 2'b00, 3'd0, 2'b00, 3'd0), 12'd10, 32'h7000, 32'h8000);
    serve_grant(-1, 3);
    expect_end(3, 0, 1'b0, 1'b1);
  endtask

  task automatic zero_size();
    grant(make_csr(3'd2, 2'b00, 3'd2, 2'b00, 3'd2), 12'd0, 32'h9000, 32'hA000);
    serve_grant(-1, -1);
    expect_end(0, 0, 1'b1, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h4c84));
    HRSTn     = 1'b0;
    arb_req   = 1'b0;
    arb_chcsr = '0;
    arb_chtsz = '0;
    arb_chsad = '0;
    arb_chdad = '0;
    arb_chabt = 1'b0;
    m_rdy     = 1'b0;
    m_err     = 1'b0;
    repeat (8) @(posedge HCLK);
    @(negedge HCLK);
    HRSTn = 1'b1;
    expect_eq("de_st", 32'(de_st), 32'(dma_state_pkg::ST_IDLE));
    expect_eq("m_arb_dst", 32'(m_arb_dst), 32'd0);
    expect_eq("de_ack", 32'(de_ack), 32'd0);
    short_xfer();
    two_grant_xfer();
    addr_modes();
    read_error();
    mid_abort();
    zero_size();
    if (dut.u_assert.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_run("Concurrent assertions on the engine reported failures");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/dma_cfg_pkg.sv
verilog/dma_state_pkg.sv
verilog/dma_csr_decode.sv
verilog/dma_xfer_fsm.sv
verilog/dma_addr_update.sv
verilog/dma_status.sv
verilog/dma_engine.sv
tb/dma_engine_assertions.sv
tb/dma_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dma_engine_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
